/* verilog/sms_bus_pkg.sv */
package sms_bus_pkg;

  // ========================================================================
  // Widths
  // ========================================================================
  localparam int c_cpu_addr_width  = 16;
  localparam int c_vram_addr_width = 14;
  localparam int c_rom_addr_width  = 24;
  localparam int c_btn_width       = 7;
  localparam int c_spritex_width   = 5;

  typedef logic [7:0]                   byte_t;
  typedef logic [c_cpu_addr_width-1:0]  cpu_addr_t;
  typedef logic [c_vram_addr_width-1:0] vram_addr_t;
  typedef logic [c_rom_addr_width-1:0]  rom_addr_t;

  // Decoded I/O port, from address bits 7:6 and bit 0
  typedef enum logic [3:0] {
    port_mem_ctrl  = 4'd0,
    port_v_counter = 4'd1,
    port_h_counter = 4'd2,
    port_psg       = 4'd3,
    port_vdp_data  = 4'd4,
    port_vdp_ctrl  = 4'd5,
    port_joy_0     = 4'd6,
    port_joy_1     = 4'd7,
    port_none      = 4'd8
  } io_port_t;

  // ========================================================================
  // Reset values and addresses
  // ========================================================================
  localparam int        c_vdp_reg_count  = 11;
  localparam byte_t     c_mem_ctrl_reset = 8'hF7;
  localparam byte_t     c_slot_reset_0   = 8'h00;
  localparam byte_t     c_slot_reset_1   = 8'h01;
  localparam byte_t     c_slot_reset_2   = 8'h02;
  localparam cpu_addr_t c_mapper_base    = 16'hFFFC;  // Misc, then slots 0 to 2

  localparam logic [c_spritex_width-1:0] c_spritex_none = '1;

  // VDP status byte, MSB first
  typedef struct packed {
    logic                       int_flag;
    logic                       overflow;
    logic                       collision;
    logic [c_spritex_width-1:0] spritex;
  } status_t;

endpackage

/* verilog/cpu_bus_if.sv */
interface cpu_bus_if;
  import sms_bus_pkg::*;

  cpu_addr_t addr;
  byte_t     wdata;     // Z80 data out
  logic      io_rd;     // Active high strobes
  logic      io_wr;
  logic      mem_rd;
  logic      mem_wr;
  io_port_t  io_port;
  logic      bus_edge;  // One cycle per CPU clock period

  // Strobe decode side
  modport source (
    output addr, wdata, io_rd, io_wr, mem_rd, mem_wr, io_port
  );

  // Clock enable side
  modport timing (
    output bus_edge
  );

  // Register blocks
  modport sink (
    input addr, wdata, io_rd, io_wr, mem_rd, mem_wr, io_port, bus_edge
  );

endinterface

/* verilog/cpu_clock_enable.sv */
module cpu_clock_enable #(
  parameter int c_cpu_clock_divide = 7
) (
  input  logic      i_clk,
  input  logic      i_n_reset,
  cpu_bus_if.timing bus
);

  localparam int c_count_width = $clog2(c_cpu_clock_divide);
  localparam logic [c_count_width-1:0] c_count_last =
    c_count_width'(c_cpu_clock_divide - 1);

  logic [c_count_width-1:0] count;

  // Free running divider, wraps at the last count
  always_ff @(posedge i_clk) begin
    if (!i_n_reset) begin
      count <= '0;
    end else if (count == c_count_last) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  assign bus.bus_edge = (count == c_count_last);  // Last cycle of each period

endmodule

/* verilog/io_read_select.sv */
module io_read_select (
  input  logic                               i_clk,
  input  sms_bus_pkg::cpu_addr_t             i_cpu_addr,
  input  sms_bus_pkg::byte_t                 i_cpu_data,
  input  logic                               i_n_rd,
  input  logic                               i_n_wr,
  input  logic                               i_n_mreq,
  input  logic                               i_n_iorq,
  input  sms_bus_pkg::byte_t                 i_vram_dout,
  input  sms_bus_pkg::byte_t                 i_status,
  input  sms_bus_pkg::byte_t                 i_v_counter,
  input  sms_bus_pkg::byte_t                 i_h_counter,
  input  logic [sms_bus_pkg::c_btn_width-1:0] i_btn,
  input  sms_bus_pkg::byte_t                 i_bios_dout,
  input  sms_bus_pkg::byte_t                 i_rom_dout,
  input  sms_bus_pkg::byte_t                 i_ram_dout,
  input  logic                               i_bios_select,
  cpu_bus_if.source                          bus,
  output sms_bus_pkg::byte_t                 o_cpu_data
);
  import sms_bus_pkg::*;

  localparam byte_t c_joy_1_data = 8'hBF;  // No second pad

  logic                   io_rd;
  logic                   io_wr;
  logic                   mem_rd;
  io_port_t               io_port;
  logic [c_btn_width-1:0] btn_q;
  byte_t                  joy_0_data;

  // Z80 pins are active low
  assign io_rd  = !i_n_rd && !i_n_iorq;
  assign io_wr  = !i_n_wr && !i_n_iorq;
  assign mem_rd = !i_n_rd && !i_n_mreq;

  assign bus.addr    = i_cpu_addr;
  assign bus.wdata   = i_cpu_data;
  assign bus.io_rd   = io_rd;
  assign bus.io_wr   = io_wr;
  assign bus.mem_rd  = mem_rd;
  assign bus.mem_wr  = !i_n_wr && !i_n_mreq;
  assign bus.io_port = io_port;

  // ========================================================================
  // Port decode
  // ========================================================================
  always_comb begin
    case ({i_cpu_addr[7:6], i_cpu_addr[0]})
      3'b000:  io_port = port_mem_ctrl;
      3'b001:  io_port = port_none;       // Joypad control, ignored
      3'b010:  io_port = port_v_counter;
      3'b011:  io_port = io_wr ? port_psg : port_h_counter;
      3'b100:  io_port = port_vdp_data;
      3'b101:  io_port = port_vdp_ctrl;
      3'b110:  io_port = port_joy_0;
      default: io_port = port_joy_1;
    endcase
  end

  always_ff @(posedge i_clk) begin
    btn_q <= i_btn;
  end

  // Buttons pull low when pressed
  assign joy_0_data = {2'b11, ~btn_q[2:1], ~btn_q[6:3]};

  // ========================================================================
  // Read data back to the CPU
  // ========================================================================
  always_comb begin
    if (io_rd && io_port == port_vdp_data) begin
      o_cpu_data = i_vram_dout;
    end else if (io_rd && io_port == port_vdp_ctrl) begin
      o_cpu_data = i_status;
    end else if (io_rd && io_port == port_joy_0) begin
      o_cpu_data = joy_0_data;
    end else if (io_rd && io_port == port_joy_1) begin
      o_cpu_data = c_joy_1_data;
    end else if (io_rd && io_port == port_v_counter) begin
      o_cpu_data = i_v_counter;
    end else if (io_rd && io_port == port_h_counter) begin
      o_cpu_data = i_h_counter;
    end else if (mem_rd && i_cpu_addr[15:14] != 2'b11) begin
      o_cpu_data = i_bios_select ? i_bios_dout : i_rom_dout;  // Lower 48K
    end else begin
      o_cpu_data = i_ram_dout;
    end
  end

endmodule

/* verilog/vdp_port_ctrl.sv */
module vdp_port_ctrl (
  input  logic                                   i_clk,
  input  logic                                   i_n_reset,
  input  logic                                   i_interrupt_flag,
  input  logic                                   i_sprite_collision,
  input  logic                                   i_too_many_sprites,
  input  logic [sms_bus_pkg::c_spritex_width-1:0] i_spritex,
  cpu_bus_if.sink                                bus,
  output sms_bus_pkg::vram_addr_t                o_vram_addr,
  output logic                                   o_vram_wr,
  output logic                                   o_vram_rd,
  output logic                                   o_cram_selected,
  output sms_bus_pkg::byte_t                     o_status,
  output logic [2:0]                             o_vdp_mode,
  output sms_bus_pkg::vram_addr_t                o_name_table_addr,
  output sms_bus_pkg::byte_t                     o_x_scroll,
  output sms_bus_pkg::byte_t                     o_y_scroll
);
  import sms_bus_pkg::*;

  logic       data_wr;
  logic       data_rd;
  logic       ctrl_wr;
  logic       ctrl_rd;
  vram_addr_t vram_addr;
  logic       cram_selected;
  logic       second_byte;           // Latch flag
  byte_t      first_byte;
  logic       data_rd_q;
  logic       status_rd_q;
  logic       int_flag_q;
  logic       collision_q;
  byte_t      vdp_regs [c_vdp_reg_count];
  status_t    status;

  assign data_wr = bus.io_wr && (bus.io_port == port_vdp_data);
  assign data_rd = bus.io_rd && (bus.io_port == port_vdp_data);
  assign ctrl_wr = bus.io_wr && (bus.io_port == port_vdp_ctrl);
  assign ctrl_rd = bus.io_rd && (bus.io_port == port_vdp_ctrl);

  // ========================================================================
  // Control port and VRAM address
  // ========================================================================
  always_ff @(posedge i_clk) begin
    if (!i_n_reset) begin
      vram_addr     <= '0;
      cram_selected <= 1'b0;
      second_byte   <= 1'b0;
      data_rd_q     <= 1'b0;
      for (int i = 0; i < c_vdp_reg_count; i++) begin
        vdp_regs[i] <= '0;
      end
    end else if (bus.bus_edge) begin
      if (data_wr) vram_addr <= vram_addr + 1'b1;
      // Bump once the read cycle is over
      data_rd_q <= data_rd;
      if (data_rd_q && !data_rd) vram_addr <= vram_addr + 1'b1;

      if (ctrl_rd || data_rd || data_wr) second_byte <= 1'b0;

      if (ctrl_wr) begin
        second_byte <= !second_byte;
        if (!second_byte) begin
          first_byte <= bus.wdata;
        end else if (!bus.wdata[7]) begin
          // VRAM address, bit 6 only says read or write
          vram_addr     <= {bus.wdata[5:0], first_byte};
          cram_selected <= 1'b0;
        end else if (bus.wdata[7:6] == 2'b10 && bus.wdata[3:0] < c_vdp_reg_count) begin
          vdp_regs[bus.wdata[3:0]] <= first_byte;
        end else begin
          vram_addr     <= {8'h00, first_byte[5:0]};  // Palette entry
          cram_selected <= 1'b1;
        end
      end
    end
  end

  // Pulses aligned with the CPU strobe
  assign o_vram_wr       = bus.bus_edge && data_wr;
  assign o_vram_rd       = bus.bus_edge && data_rd;
  assign o_vram_addr     = vram_addr;
  assign o_cram_selected = cram_selected;

  // ========================================================================
  // Sticky status flags
  // ========================================================================
  always_ff @(posedge i_clk) begin
    if (!i_n_reset) begin
      int_flag_q  <= 1'b0;
      collision_q <= 1'b0;
      status_rd_q <= 1'b0;
    end else begin
      if (i_interrupt_flag) int_flag_q <= 1'b1;
      if (i_sprite_collision) collision_q <= 1'b1;
      if (bus.bus_edge) begin
        status_rd_q <= ctrl_rd;
        if (status_rd_q && !ctrl_rd) begin  // Clear wins over a new set
          int_flag_q  <= 1'b0;
          collision_q <= 1'b0;
        end
      end
    end
  end

  assign status.int_flag  = int_flag_q;
  assign status.overflow  = i_too_many_sprites;
  assign status.collision = collision_q;
  assign status.spritex   = i_too_many_sprites ? i_spritex : c_spritex_none;
  assign o_status         = status;

  // Mode 4 takes priority over the TMS modes
  always_comb begin
    if (vdp_regs[0][2]) begin
      o_vdp_mode = 3'd4;
    end else if (vdp_regs[1][3]) begin
      o_vdp_mode = 3'd3;
    end else if (vdp_regs[0][1]) begin
      o_vdp_mode = 3'd2;
    end else if (vdp_regs[1][4]) begin
      o_vdp_mode = 3'd1;
    end else begin
      o_vdp_mode = 3'd0;
    end
  end

  assign o_name_table_addr = {vdp_regs[2][3:1], 11'b0};
  assign o_x_scroll        = vdp_regs[8];
  assign o_y_scroll        = vdp_regs[9];

endmodule

/* verilog/memory_mapper.sv */
module memory_mapper (
  input  logic                   i_clk,
  input  logic                   i_n_reset,
  cpu_bus_if.sink                bus,
  output sms_bus_pkg::rom_addr_t o_rom_addr,
  output logic                   o_ram_we,
  output logic                   o_bios_select
);
  import sms_bus_pkg::*;

  logic  mapper_wr;
  logic  mem_ctrl_wr;
  byte_t mapper_regs [4];  // Misc at index 0, then slots 0 to 2
  byte_t mem_ctrl;

  // FFFC to FFFF
  assign mapper_wr   = bus.mem_wr && (bus.addr[15:2] == c_mapper_base[15:2]);
  assign mem_ctrl_wr = bus.io_wr && (bus.io_port == port_mem_ctrl);

  // ========================================================================
  // Mapper and memory control registers
  // ========================================================================
  always_ff @(posedge i_clk) begin
    if (!i_n_reset) begin
      mapper_regs[0] <= '0;
      mapper_regs[1] <= c_slot_reset_0;
      mapper_regs[2] <= c_slot_reset_1;
      mapper_regs[3] <= c_slot_reset_2;
      mem_ctrl       <= c_mem_ctrl_reset;
    end else if (bus.bus_edge) begin
      if (mapper_wr) mapper_regs[bus.addr[1:0]] <= bus.wdata;
      if (mem_ctrl_wr) mem_ctrl <= bus.wdata;
    end
  end

  // Cartridge address from the slot of each 16K quarter
  always_comb begin
    case (bus.addr[15:14])
      2'd0:    o_rom_addr = {2'b00, mapper_regs[1], bus.addr[13:0]};
      2'd1:    o_rom_addr = {2'b00, mapper_regs[2], bus.addr[13:0]};
      2'd2:    o_rom_addr = {2'b00, mapper_regs[3], bus.addr[13:0]};
      default: o_rom_addr = {8'h00, bus.addr};  // RAM quarter, unmapped
    endcase
  end

  assign o_ram_we      = bus.bus_edge && bus.mem_wr && (bus.addr[15:14] == 2'b11);
  assign o_bios_select = !mem_ctrl[3];  // Bit 3 low enables the BIOS

endmodule

/* verilog/sms_bus_ctrl.sv */
module sms_bus_ctrl #(
  parameter int c_cpu_clock_divide = 7
) (
  input  logic                                   i_n_hard_reset,
  input  logic                                   cpuClock,
  // Z80 pins
  input  sms_bus_pkg::cpu_addr_t                 i_cpu_addr,
  input  sms_bus_pkg::byte_t                     i_cpu_data,
  input  logic                                   i_n_rd,
  input  logic                                   i_n_wr,
  input  logic                                   i_n_mreq,
  input  logic                                   i_n_iorq,
  output sms_bus_pkg::byte_t                     o_cpu_data,
  // Video side
  input  sms_bus_pkg::byte_t                     i_vram_dout,
  input  sms_bus_pkg::byte_t                     i_v_counter,
  input  sms_bus_pkg::byte_t                     i_h_counter,
  input  logic                                   i_interrupt_flag,
  input  logic                                   i_sprite_collision,
  input  logic                                   i_too_many_sprites,
  input  logic [sms_bus_pkg::c_spritex_width-1:0] i_spritex,
  output sms_bus_pkg::vram_addr_t                o_vram_addr,
  output logic                                   o_vram_wr,
  output logic                                   o_vram_rd,
  output logic                                   o_cram_selected,
  output logic [2:0]                             o_vdp_mode,
  output sms_bus_pkg::vram_addr_t                o_name_table_addr,
  output sms_bus_pkg::byte_t                     o_x_scroll,
  output sms_bus_pkg::byte_t                     o_y_scroll,
  // Memories and pad
  input  logic [sms_bus_pkg::c_btn_width-1:0]    i_btn,
  input  sms_bus_pkg::byte_t                     i_bios_dout,
  input  sms_bus_pkg::byte_t                     i_rom_dout,
  input  sms_bus_pkg::byte_t                     i_ram_dout,
  output sms_bus_pkg::rom_addr_t                 o_rom_addr,
  output logic                                   o_ram_we,
  output logic                                   o_bios_select
);
  import sms_bus_pkg::*;

  byte_t status;

  cpu_bus_if u_bus ();

  cpu_clock_enable #(
    .c_cpu_clock_divide(c_cpu_clock_divide)
  ) u_cpu_clock_enable (
    .i_clk     (cpuClock),
    .i_n_reset (i_n_hard_reset),
    .bus       (u_bus.timing)
  );

  io_read_select u_io_read_select (
    .i_clk         (cpuClock),
    .i_cpu_addr    (i_cpu_addr),
    .i_cpu_data    (i_cpu_data),
    .i_n_rd        (i_n_rd),
    .i_n_wr        (i_n_wr),
    .i_n_mreq      (i_n_mreq),
    .i_n_iorq      (i_n_iorq),
    .i_vram_dout   (i_vram_dout),
    .i_status      (status),
    .i_v_counter   (i_v_counter),
    .i_h_counter   (i_h_counter),
    .i_btn         (i_btn),
    .i_bios_dout   (i_bios_dout),
    .i_rom_dout    (i_rom_dout),
    .i_ram_dout    (i_ram_dout),
    .i_bios_select (o_bios_select),
    .bus           (u_bus.source),
    .o_cpu_data    (o_cpu_data)
  );

  vdp_port_ctrl u_vdp_port_ctrl (
    .i_clk              (cpuClock),
    .i_n_reset          (i_n_hard_reset),
    .i_interrupt_flag   (i_interrupt_flag),
    .i_sprite_collision (i_sprite_collision),
    .i_too_many_sprites (i_too_many_sprites),
    .i_spritex          (i_spritex),
    .bus                (u_bus.sink),
    .o_vram_addr        (o_vram_addr),
    .o_vram_wr          (o_vram_wr),
    .o_vram_rd          (o_vram_rd),
    .o_cram_selected    (o_cram_selected),
    .o_status           (status),
    .o_vdp_mode         (o_vdp_mode),
    .o_name_table_addr  (o_name_table_addr),
    .o_x_scroll         (o_x_scroll),
    .o_y_scroll         (o_y_scroll)
  );

  memory_mapper u_memory_mapper (
    .i_clk         (cpuClock),
    .i_n_reset     (i_n_hard_reset),
    .bus           (u_bus.sink),
    .o_rom_addr    (o_rom_addr),
    .o_ram_we      (o_ram_we),
    .o_bios_select (o_bios_select)
  );

endmodule

/* bench/sms_bus_model.sv */
module sms_bus_model #(
  parameter int c_cpu_clock_divide = 7
) (
  input  logic                                    i_clk,
  input  logic                                    i_n_reset,
  input  sms_bus_pkg::cpu_addr_t                  i_cpu_addr,
  input  sms_bus_pkg::byte_t                      i_cpu_data,
  input  logic                                    i_n_rd,
  input  logic                                    i_n_wr,
  input  logic                                    i_n_mreq,
  input  logic                                    i_n_iorq,
  input  sms_bus_pkg::byte_t                      i_vram_dout,
  input  sms_bus_pkg::byte_t                      i_v_counter,
  input  sms_bus_pkg::byte_t                      i_h_counter,
  input  logic                                    i_interrupt_flag,
  input  logic                                    i_sprite_collision,
  input  logic                                    i_too_many_sprites,
  input  logic [sms_bus_pkg::c_spritex_width-1:0] i_spritex,
  input  logic [sms_bus_pkg::c_btn_width-1:0]     i_btn,
  input  sms_bus_pkg::byte_t                      i_bios_dout,
  input  sms_bus_pkg::byte_t                      i_rom_dout,
  input  sms_bus_pkg::byte_t                      i_ram_dout,
  output sms_bus_pkg::byte_t                      o_cpu_data,
  output sms_bus_pkg::vram_addr_t                 o_vram_addr,
  output logic                                    o_vram_wr,
  output logic                                    o_vram_rd,
  output logic                                    o_cram_selected,
  output logic [2:0]                              o_vdp_mode,
  output sms_bus_pkg::vram_addr_t                 o_name_table_addr,
  output sms_bus_pkg::byte_t                      o_x_scroll,
  output sms_bus_pkg::byte_t                      o_y_scroll,
  output sms_bus_pkg::rom_addr_t                  o_rom_addr,
  output logic                                    o_ram_we,
  output logic                                    o_bios_select
);
  timeunit 1ns;
  timeprecision 100ps;
  import sms_bus_pkg::*;

  int                     phase;
  logic                   bus_edge;
  logic                   io_rd;
  logic                   io_wr;
  logic                   mem_rd;
  logic                   mem_wr;
  logic [2:0]             sel;        // Address bits 7:6 and 0
  logic                   stat_rd;
  logic                   dat_rd;
  logic                   dat_wr;
  logic                   ctl_wr;
  vram_addr_t             vaddr;
  logic                   cram;
  logic                   latched;    // First control byte held
  byte_t                  first;
  byte_t                  regs [c_vdp_reg_count];
  logic                   data_rd_d;
  logic                   status_rd_d;
  logic                   int_f;
  logic                   coll_f;
  byte_t                  mapper [4];  // Index is address minus FFFC
  byte_t                  mem_ctrl;
  logic [c_btn_width-1:0] btn_q;
  byte_t                  status;

  assign bus_edge = (phase == c_cpu_clock_divide - 1);
  assign io_rd    = !i_n_rd && !i_n_iorq;
  assign io_wr    = !i_n_wr && !i_n_iorq;
  assign mem_rd   = !i_n_rd && !i_n_mreq;
  assign mem_wr   = !i_n_wr && !i_n_mreq;
  assign sel      = {i_cpu_addr[7:6], i_cpu_addr[0]};
  assign stat_rd  = io_rd && sel == 3'b101;
  assign dat_rd   = io_rd && sel == 3'b100;
  assign dat_wr   = io_wr && sel == 3'b100;
  assign ctl_wr   = io_wr && sel == 3'b101;

  // ==========================================================================
  // State updates
  // ==========================================================================
  always @(posedge i_clk) begin
    btn_q <= i_btn;
    if (!i_n_reset) begin
      phase       <= 0;
      vaddr       <= '0;
      cram        <= 1'b0;
      latched     <= 1'b0;
      data_rd_d   <= 1'b0;
      status_rd_d <= 1'b0;
      int_f       <= 1'b0;
      coll_f      <= 1'b0;
      mapper      <= '{8'h00, c_slot_reset_0, c_slot_reset_1, c_slot_reset_2};
      mem_ctrl    <= c_mem_ctrl_reset;
      for (int i = 0; i < c_vdp_reg_count; i++) begin
        regs[i] <= 8'h00;
      end
    end else begin
      phase <= (phase + 1) % c_cpu_clock_divide;
      if (i_interrupt_flag) int_f <= 1'b1;
      if (i_sprite_collision) coll_f <= 1'b1;
      if (bus_edge) begin
        if (status_rd_d && !stat_rd) begin  // Status read just ended
          int_f  <= 1'b0;
          coll_f <= 1'b0;
        end
        status_rd_d <= stat_rd;
        data_rd_d   <= dat_rd;
        if (dat_wr || (data_rd_d && !dat_rd)) vaddr <= vaddr + 1'b1;
        if (stat_rd || dat_rd || dat_wr) latched <= 1'b0;
        if (ctl_wr && !latched) begin
          first   <= i_cpu_data;
          latched <= 1'b1;
        end else if (ctl_wr) begin
          latched <= 1'b0;
          if (!i_cpu_data[7]) begin
            vaddr <= {i_cpu_data[5:0], first};
            cram  <= 1'b0;
          end else if (i_cpu_data[6] == 1'b0 && i_cpu_data[3:0] < c_vdp_reg_count) begin
            regs[i_cpu_data[3:0]] <= first;
          end else begin
            vaddr <= {8'h00, first[5:0]};
            cram  <= 1'b1;
          end
        end
        if (mem_wr && i_cpu_addr >= c_mapper_base) begin
          mapper[i_cpu_addr - c_mapper_base] <= i_cpu_data;
        end
        if (io_wr && sel == 3'b000) mem_ctrl <= i_cpu_data;
      end
    end
  end

  // ==========================================================================
  // Expected outputs
  // ==========================================================================
  assign status = {int_f, i_too_many_sprites, coll_f,
                   i_too_many_sprites ? i_spritex : c_spritex_none};

  always_comb begin
    o_cpu_data = i_ram_dout;
    if (mem_rd && i_cpu_addr < 16'hC000) begin
      o_cpu_data = o_bios_select ? i_bios_dout : i_rom_dout;
    end
    if (io_rd) begin
      case (sel)
        3'b010:  o_cpu_data = i_v_counter;
        3'b011:  o_cpu_data = i_h_counter;
        3'b100:  o_cpu_data = i_vram_dout;
        3'b101:  o_cpu_data = status;
        3'b110:  o_cpu_data = {2'b11, ~btn_q[2:1], ~btn_q[6:3]};
        3'b111:  o_cpu_data = 8'hBF;   // Second pad absent
        default: ;
      endcase
    end
  end

  always_comb begin
    if (regs[0][2]) o_vdp_mode = 3'd4;
    else if (regs[1][3]) o_vdp_mode = 3'd3;
    else if (regs[0][1]) o_vdp_mode = 3'd2;
    else if (regs[1][4]) o_vdp_mode = 3'd1;
    else o_vdp_mode = 3'd0;
  end

  always_comb begin
    if (i_cpu_addr[15:14] == 2'b11) begin
      o_rom_addr = {8'h00, i_cpu_addr};
    end else begin
      o_rom_addr = {2'b00, mapper[int'(i_cpu_addr[15:14]) + 1], i_cpu_addr[13:0]};
    end
  end

  assign o_vram_addr       = vaddr;
  assign o_vram_wr         = bus_edge && dat_wr;
  assign o_vram_rd         = bus_edge && dat_rd;
  assign o_cram_selected   = cram;
  assign o_name_table_addr = {regs[2][3:1], 11'b0};
  assign o_x_scroll        = regs[8];
  assign o_y_scroll        = regs[9];
  assign o_ram_we          = bus_edge && mem_wr && i_cpu_addr[15:14] == 2'b11;
  assign o_bios_select     = !mem_ctrl[3];

endmodule

/* bench/tb_sms_bus_ctrl.sv */
module tb_sms_bus_ctrl;
  timeunit 1ns;
  timeprecision 100ps;
  import sms_bus_pkg::*;

  localparam int c_divide       = 7;
  localparam int c_reset_cycles = 10;
  localparam int c_bus_cycles   = 3000;
  localparam int c_cycle_limit  = c_reset_cycles + (c_bus_cycles + 1) * c_divide + 100;
  localparam int c_seed         = 32'hd454_e300;

  // Strobe kinds
  localparam int c_idle   = 0;
  localparam int c_io_wr  = 1;
  localparam int c_io_rd  = 2;
  localparam int c_mem_rd = 3;
  localparam int c_mem_wr = 4;

  logic                   cpuClock;
  logic                   n_hard_reset;
  cpu_addr_t              cpu_addr;
  byte_t                  cpu_data;
  logic                   n_rd;
  logic                   n_wr;
  logic                   n_mreq;
  logic                   n_iorq;
  byte_t                  vram_dout;
  byte_t                  v_counter;
  byte_t                  h_counter;
  logic                   interrupt_flag;
  logic                   sprite_collision;
  logic                   too_many_sprites;
  logic [c_spritex_width-1:0] spritex;
  logic [c_btn_width-1:0] btn;
  byte_t                  bios_dout;
  byte_t                  rom_dout;
  byte_t                  ram_dout;

  byte_t      dut_cpu_data, exp_cpu_data;
  vram_addr_t dut_vram_addr, exp_vram_addr;
  logic       dut_vram_wr, exp_vram_wr;
  logic       dut_vram_rd, exp_vram_rd;
  logic       dut_cram, exp_cram;
  logic [2:0] dut_mode, exp_mode;
  vram_addr_t dut_name_table, exp_name_table;
  byte_t      dut_x_scroll, exp_x_scroll;
  byte_t      dut_y_scroll, exp_y_scroll;
  rom_addr_t  dut_rom_addr, exp_rom_addr;
  logic       dut_ram_we, exp_ram_we;
  logic       dut_bios_sel, exp_bios_sel;

  int   errors;
  int   checks;
  int   cycle_count;
  logic checking;
  int   seed_ret;

  always #2 cpuClock = ~cpuClock;

  sms_bus_ctrl #(
    .c_cpu_clock_divide(c_divide)
  ) u_sms_bus_ctrl (
    .i_n_hard_reset(n_hard_reset), .cpuClock(cpuClock),
    .i_cpu_addr(cpu_addr), .i_cpu_data(cpu_data), .i_n_rd(n_rd), .i_n_wr(n_wr),
    .i_n_mreq(n_mreq), .i_n_iorq(n_iorq), .o_cpu_data(dut_cpu_data),
    .i_vram_dout(vram_dout), .i_v_counter(v_counter), .i_h_counter(h_counter),
    .i_interrupt_flag(interrupt_flag), .i_sprite_collision(sprite_collision),
    .i_too_many_sprites(too_many_sprites), .i_spritex(spritex),
    .o_vram_addr(dut_vram_addr), .o_vram_wr(dut_vram_wr), .o_vram_rd(dut_vram_rd),
    .o_cram_selected(dut_cram), .o_vdp_mode(dut_mode),
    .o_name_table_addr(dut_name_table), .o_x_scroll(dut_x_scroll),
    .o_y_scroll(dut_y_scroll), .i_btn(btn), .i_bios_dout(bios_dout),
    .i_rom_dout(rom_dout), .i_ram_dout(ram_dout), .o_rom_addr(dut_rom_addr),
    .o_ram_we(dut_ram_we), .o_bios_select(dut_bios_sel)
  );

  sms_bus_model #(
    .c_cpu_clock_divide(c_divide)
  ) u_sms_bus_model (
    .i_clk(cpuClock), .i_n_reset(n_hard_reset),
    .i_cpu_addr(cpu_addr), .i_cpu_data(cpu_data), .i_n_rd(n_rd), .i_n_wr(n_wr),
    .i_n_mreq(n_mreq), .i_n_iorq(n_iorq), .i_vram_dout(vram_dout),
    .i_v_counter(v_counter), .i_h_counter(h_counter),
    .i_interrupt_flag(interrupt_flag), .i_sprite_collision(sprite_collision),
    .i_too_many_sprites(too_many_sprites), .i_spritex(spritex), .i_btn(btn),
    .i_bios_dout(bios_dout), .i_rom_dout(rom_dout), .i_ram_dout(ram_dout),
    .o_cpu_data(exp_cpu_data), .o_vram_addr(exp_vram_addr),
    .o_vram_wr(exp_vram_wr), .o_vram_rd(exp_vram_rd), .o_cram_selected(exp_cram),
    .o_vdp_mode(exp_mode), .o_name_table_addr(exp_name_table),
    .o_x_scroll(exp_x_scroll), .o_y_scroll(exp_y_scroll),
    .o_rom_addr(exp_rom_addr), .o_ram_we(exp_ram_we), .o_bios_select(exp_bios_sel)
  );

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR t=%0t %s: got %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // Side inputs change with every bus cycle
  task automatic randomize_side_inputs();
    vram_dout        = byte_t'($urandom);
    v_counter        = byte_t'($urandom);
    h_counter        = byte_t'($urandom);
    bios_dout        = byte_t'($urandom);
    rom_dout         = byte_t'($urandom);
    ram_dout         = byte_t'($urandom);
    btn              = c_btn_width'($urandom);
    spritex          = c_spritex_width'($urandom);
    interrupt_flag   = ($urandom_range(0, 7) == 0);
    sprite_collision = ($urandom_range(0, 7) == 0);
    too_many_sprites = ($urandom_range(0, 3) == 0);
  endtask

  // Holds one bus cycle for a full divide period, so it spans one strobe
  task automatic drive_bus_cycle(input int kind, input cpu_addr_t addr, input byte_t data);
    cpu_addr = addr;
    cpu_data = data;
    n_rd     = !(kind == c_io_rd || kind == c_mem_rd);
    n_wr     = !(kind == c_io_wr || kind == c_mem_wr);
    n_iorq   = !(kind == c_io_rd || kind == c_io_wr);
    n_mreq   = !(kind == c_mem_rd || kind == c_mem_wr);
    randomize_side_inputs();
    repeat (c_divide) @(posedge cpuClock);
    #1;
  endtask

  task automatic run_random_cycle();
    int        pick;
    int        kind;
    cpu_addr_t addr;
    pick = $urandom_range(0, 9);
    addr = cpu_addr_t'($urandom);
    if (pick == 0) kind = c_idle;
    else if (pick <= 3) kind = c_io_wr;
    else if (pick <= 5) kind = c_io_rd;
    else if (pick <= 7) kind = c_mem_rd;
    else kind = c_mem_wr;
    if ((kind == c_io_wr || kind == c_io_rd) && $urandom_range(0, 1) == 1) begin
      addr[7:6] = 2'b10;        // VDP ports
    end
    if ((kind == c_mem_wr || kind == c_mem_rd) && $urandom_range(0, 3) == 0) begin
      addr[15:2] = 14'h3FFF;    // Mapper registers
    end
    drive_bus_cycle(kind, addr, byte_t'($urandom));
  endtask

  // ==========================================================================
  // Compare at the falling edge, away from input changes
  // ==========================================================================
  always @(negedge cpuClock) begin
    if (checking) begin
      check_value("o_cpu_data", dut_cpu_data, exp_cpu_data);
      check_value("o_vram_addr", dut_vram_addr, exp_vram_addr);
      check_value("o_vram_wr", dut_vram_wr, exp_vram_wr);
      check_value("o_vram_rd", dut_vram_rd, exp_vram_rd);
      check_value("o_cram_selected", dut_cram, exp_cram);
      check_value("o_vdp_mode", dut_mode, exp_mode);
      check_value("o_name_table_addr", dut_name_table, exp_name_table);
      check_value("o_x_scroll", dut_x_scroll, exp_x_scroll);
      check_value("o_y_scroll", dut_y_scroll, exp_y_scroll);
      check_value("o_rom_addr", dut_rom_addr, exp_rom_addr);
      check_value("o_ram_we", dut_ram_we, exp_ram_we);
      check_value("o_bios_select", dut_bios_sel, exp_bios_sel);
    end
  end

  always @(posedge cpuClock) begin
    cycle_count++;
    if (cycle_count > c_cycle_limit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", c_cycle_limit);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    cpuClock     = 1'b0;
    n_hard_reset = 1'b0;
    errors       = 0;
    checks       = 0;
    cycle_count  = 0;
    checking     = 1'b0;
    cpu_addr     = '0;
    cpu_data     = '0;
    n_rd         = 1'b1;
    n_wr         = 1'b1;
    n_mreq       = 1'b1;
    n_iorq       = 1'b1;
    seed_ret     = $urandom(c_seed);
    randomize_side_inputs();

    repeat (c_reset_cycles) @(posedge cpuClock);
    #1;
    n_hard_reset = 1'b1;
    checking     = 1'b1;

    // First cycle is a RAM write, so the first o_ram_we pulse shows strobe timing
    drive_bus_cycle(c_mem_wr, 16'hC000 | cpu_addr_t'($urandom_range(0, 16'h3FFB)),
                    byte_t'($urandom));
    for (int n = 1; n < c_bus_cycles; n++) begin
      run_random_cycle();
    end
    drive_bus_cycle(c_idle, 16'h0000, 8'h00);
    checking = 1'b0;

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* build.f */
verilog/sms_bus_pkg.sv
verilog/cpu_bus_if.sv
verilog/cpu_clock_enable.sv
verilog/io_read_select.sv
verilog/vdp_port_ctrl.sv
verilog/memory_mapper.sv
verilog/sms_bus_ctrl.sv
bench/sms_bus_model.sv
bench/tb_sms_bus_ctrl.sv
